// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // geometry
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int WAYS     = 2;
    localparam int BANKS    = 4;    // words per line
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 128;
    localparam int SETS     = 256;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] strb_t;
    typedef logic [LINE_W-1:0]   line_t;

    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] paddr_t;   // line aligned on the bus
    typedef logic [$clog2(BANKS)-1:0]          bank_sel_t;

    // tag RAM word, valid in bit 0
    typedef logic [TAG_W:0] tagv_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } main_state_t;

    typedef enum logic {
        sb_idle,
        sb_write
    } sb_state_t;

endpackage

`default_nettype wire

// ==== rtl/sync_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

// one set per address, read data one cycle after the address
module sync_ram
    import cache_pkg::*;
#(
    parameter int WIDTH = WORD_W,
    parameter int LANES = WORD_W / 8
) (
    input  wire              clk,
    input  wire  [LANES-1:0] we,
    input  wire  index_t     addr,
    input  wire  [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] mem [SETS];

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we[l]) begin
                mem[addr][l*(WIDTH/LANES) +: WIDTH/LANES] <= din[l*(WIDTH/LANES) +: WIDTH/LANES];
            end
        end
        dout <= mem[addr];    // old contents on a same-cycle write
    end

endmodule

`default_nettype wire

// ==== cache/cache_lookup.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_lookup
    import cache_pkg::*;
(
    input  wire              clk,
    input  wire              resetn,
    input  wire              valid,
    input  wire              op,            // 1 = store
    input  wire  index_t     index,
    input  wire  tag_t       tag,
    input  wire  offset_t    offset,
    input  wire  strb_t      wstrb,
    input  wire  word_t      wdata,
    input  wire  main_state_t state,
    input  wire              init_busy,
    input  wire  index_t     init_index,
    input  wire              sb_pending,
    input  wire  bank_sel_t  sb_busy_bank,
    input  wire  tagv_t      tagv_rdata0,
    input  wire  tagv_t      tagv_rdata1,
    input  wire  word_t      bank_rdata [WAYS*BANKS],
    output logic             addr_ok,
    output index_t           ram_index,
    output logic             req_op,
    output index_t           req_index,
    output tag_t             req_tag,
    output bank_sel_t        req_bank,
    output strb_t            req_wstrb,
    output word_t            req_wdata,
    output logic             hit,
    output logic             hit_way,
    output word_t            hit_word
);

    logic      hit0;
    logic      hit1;
    logic      raw_lookup;
    logic      raw_sb;
    bank_sel_t in_bank;

    assign in_bank = offset[OFFSET_W-1:2];    // byte offset dropped

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_op <= 1'b0;
        end else if (valid && addr_ok) begin
            req_op <= op;
        end
    end

    // request buffer payload
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= in_bank;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    assign hit0     = tagv_rdata0[0] && (tagv_rdata0[TAG_W:1] == req_tag);
    assign hit1     = tagv_rdata1[0] && (tagv_rdata1[TAG_W:1] == req_tag);
    assign hit      = (state == lookup) && (hit0 || hit1);
    assign hit_way  = hit1;
    assign hit_word = bank_rdata[{hit_way, req_bank}];

    // store in lookup now, its bank gets written a cycle later
    assign raw_lookup = hit && req_op && !op && (index == req_index) && (in_bank == req_bank);
    // store buffer holds this bank's port in the coming edge
    assign raw_sb     = sb_pending && !op && (in_bank == sb_busy_bank);

    assign addr_ok = !init_busy && ((state == idle) || hit) && !raw_lookup && !raw_sb;

    always_comb begin
        if (init_busy) begin
            ram_index = init_index;    // tag clear sweep
        end else if ((state == idle) || hit) begin
            ram_index = index;
        end else begin
            ram_index = req_index;     // miss path rereads the buffered set
        end
    end

endmodule

`default_nettype wire

// ==== cache/cache_miss_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_miss_ctrl
    import cache_pkg::*;
(
    input  wire              clk,
    input  wire              resetn,
    input  wire              valid,
    input  wire              addr_ok,
    input  wire              hit,
    input  wire              hit_way,
    input  wire              req_op,
    input  wire  index_t     req_index,
    input  wire  tag_t       req_tag,
    input  wire  bank_sel_t  req_bank,
    input  wire  strb_t      req_wstrb,
    input  wire  tagv_t      tagv_rdata0,
    input  wire  tagv_t      tagv_rdata1,
    input  wire  word_t      bank_rdata [WAYS*BANKS],
    input  wire              rd_rdy,
    input  wire              ret_valid,
    input  wire              ret_last,
    input  wire              wr_rdy,
    output main_state_t      state,
    output logic             victim_way,
    output logic             refill_we,
    output bank_sel_t        refill_bank,
    output logic [WAYS-1:0]  tag_we,
    output tagv_t            tag_wdata,
    output logic             init_busy,
    output index_t           init_index,
    output logic             miss_data_ok,
    output logic             rd_req,
    output paddr_t           rd_addr,
    output logic             wr_req,
    output paddr_t           wr_addr,
    output line_t            wr_data
);

    main_state_t     next_state;
    logic [SETS-1:0] lru;            // victim way of each set
    logic [SETS-1:0] dirty [WAYS];
    logic            wb_wait;
    logic            victim_dirty;
    logic            refill_done;
    tagv_t           victim_tagv;
    bank_sel_t       ret_cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (valid && addr_ok) next_state = lookup;
            end
            lookup: begin
                if (!hit) begin
                    next_state = miss;
                end else if (!(valid && addr_ok)) begin
                    next_state = idle;
                end
            end
            miss: begin
                if (!victim_dirty || wr_req) next_state = replace;
            end
            replace: begin
                if (rd_rdy) next_state = refill;
            end
            refill: begin
                if (refill_done) next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

    // clear every tag valid bit after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            init_busy  <= 1'b1;
            init_index <= '0;
        end else if (init_busy) begin
            init_index <= init_index + 1'b1;
            if (init_index == index_t'(SETS - 1)) init_busy <= 1'b0;
        end
    end

    // first miss cycle may read a bank the store buffer was writing
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_wait <= 1'b0;
        end else begin
            wb_wait <= (state == lookup) && !hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ret_cnt <= '0;
        end else if (refill_we) begin
            ret_cnt <= ret_last ? bank_sel_t'(0) : ret_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lru <= '0;
            for (int w = 0; w < WAYS; w++) dirty[w] <= '0;
        end else if (hit) begin
            lru[req_index] <= ~hit_way;
            if (req_op && |req_wstrb) dirty[hit_way][req_index] <= 1'b1;
        end else if (refill_done) begin
            lru[req_index]               <= ~victim_way;    // filled way now most recent
            dirty[victim_way][req_index] <= req_op && |req_wstrb;
        end
    end

    assign victim_way   = lru[req_index];
    assign victim_tagv  = victim_way ? tagv_rdata1 : tagv_rdata0;
    assign victim_dirty = victim_tagv[0] && dirty[victim_way][req_index];

    assign refill_we    = (state == refill) && ret_valid;
    assign refill_done  = refill_we && ret_last;
    assign refill_bank  = ret_cnt;
    assign miss_data_ok = refill_we && (req_op ? ret_last : (ret_cnt == req_bank));

    for (genvar w = 0; w < WAYS; w++) begin : g_tag_we
        assign tag_we[w] = init_busy || (refill_we && (ret_cnt == '0) && (victim_way == 1'(w)));
    end
    assign tag_wdata = init_busy ? tagv_t'(0) : {req_tag, 1'b1};

    assign rd_req  = (state == replace);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    assign wr_req  = (state == miss) && victim_dirty && !wb_wait && wr_rdy;
    assign wr_addr = {victim_tagv[TAG_W:1], req_index, {OFFSET_W{1'b0}}};
    assign wr_data = {bank_rdata[{victim_way, 2'd3}], bank_rdata[{victim_way, 2'd2}],
                      bank_rdata[{victim_way, 2'd1}], bank_rdata[{victim_way, 2'd0}]};

endmodule

`default_nettype wire

// ==== cache/cache_store_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_store_buffer
    import cache_pkg::*;
(
    input  wire              clk,
    input  wire              resetn,
    input  wire  main_state_t state,
    input  wire              hit,
    input  wire              hit_way,
    input  wire              req_op,
    input  wire  index_t     req_index,
    input  wire  bank_sel_t  req_bank,
    input  wire  strb_t      req_wstrb,
    input  wire  word_t      req_wdata,
    input  wire  word_t      hit_word,
    input  wire              refill_we,
    input  wire  bank_sel_t  refill_bank,
    input  wire              victim_way,
    input  wire              ret_valid,
    input  wire  word_t      ret_data,
    input  wire              miss_data_ok,
    output strb_t            bank_we [WAYS*BANKS],
    output word_t            bank_wdata [BANKS],
    output logic             sb_pending,
    output index_t           sb_busy_index,
    output bank_sel_t        sb_busy_bank,
    output logic             data_ok,
    output word_t            rdata
);

    sb_state_t sb_state;
    logic      sb_way;
    strb_t     sb_wstrb;
    word_t     sb_wdata;
    word_t     refill_word;
    logic      store_hit;

    assign store_hit = hit && req_op;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sb_state <= sb_idle;
        end else begin
            case (sb_state)
                sb_idle:  if (store_hit) sb_state <= sb_write;
                sb_write: if (!store_hit) sb_state <= sb_idle;    // back to back stores stay
                default:  sb_state <= sb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            sb_way        <= hit_way;
            sb_busy_index <= req_index;
            sb_busy_bank  <= req_bank;
            sb_wstrb      <= req_wstrb;
            sb_wdata      <= req_wdata;
        end
    end

    assign sb_pending = (sb_state == sb_write);

    // write miss bytes go straight into the refilled word
    always_comb begin
        refill_word = ret_data;
        if (req_op && (refill_bank == req_bank)) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (req_wstrb[b]) refill_word[8*b +: 8] = req_wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < WAYS * BANKS; k++) begin
            bank_we[k] = '0;
            if (sb_pending && (k == {sb_way, sb_busy_bank})) begin
                bank_we[k] = sb_wstrb;
            end else if (refill_we && (k == {victim_way, refill_bank})) begin
                bank_we[k] = '1;
            end
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_wdata
        assign bank_wdata[b] = sb_pending ? sb_wdata : refill_word;
    end

    assign data_ok = hit || miss_data_ok;
    assign rdata   = ((state == refill) && ret_valid) ? ret_data : hit_word;

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  wire          clk,
    input  wire          resetn,
    // cpu side
    input  wire          valid,
    input  wire          op,
    input  wire  index_t index,
    input  wire  tag_t   tag,
    input  wire  offset_t offset,
    input  wire  strb_t  wstrb,
    input  wire  word_t  wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,
    // memory side
    output logic         rd_req,
    output paddr_t       rd_addr,
    input  wire          rd_rdy,
    input  wire          ret_valid,
    input  wire          ret_last,
    input  wire  word_t  ret_data,
    output logic         wr_req,
    output paddr_t       wr_addr,
    output line_t        wr_data,
    input  wire          wr_rdy
);

    main_state_t     state;
    logic            init_busy;
    index_t          init_index;
    index_t          ram_index;
    logic            req_op;
    index_t          req_index;
    tag_t            req_tag;
    bank_sel_t       req_bank;
    strb_t           req_wstrb;
    word_t           req_wdata;
    logic            hit;
    logic            hit_way;
    word_t           hit_word;
    logic            victim_way;
    logic            refill_we;
    bank_sel_t       refill_bank;
    logic [WAYS-1:0] tag_we;
    tagv_t           tag_wdata;
    tagv_t           tagv_rdata [WAYS];
    logic            miss_data_ok;
    logic            sb_pending;
    index_t          sb_busy_index;
    bank_sel_t       sb_busy_bank;
    strb_t           bank_we    [WAYS*BANKS];
    word_t           bank_wdata [BANKS];
    word_t           bank_rdata [WAYS*BANKS];
    index_t          bank_addr  [WAYS*BANKS];

    cache_lookup u_lookup (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .state, .init_busy, .init_index, .sb_pending, .sb_busy_bank,
        .tagv_rdata0 (tagv_rdata[0]),
        .tagv_rdata1 (tagv_rdata[1]),
        .bank_rdata, .addr_ok, .ram_index,
        .req_op, .req_index, .req_tag, .req_bank, .req_wstrb, .req_wdata,
        .hit, .hit_way, .hit_word
    );

    cache_miss_ctrl u_miss_ctrl (
        .clk, .resetn, .valid, .addr_ok, .hit, .hit_way,
        .req_op, .req_index, .req_tag, .req_bank, .req_wstrb,
        .tagv_rdata0 (tagv_rdata[0]),
        .tagv_rdata1 (tagv_rdata[1]),
        .bank_rdata, .rd_rdy, .ret_valid, .ret_last, .wr_rdy,
        .state, .victim_way, .refill_we, .refill_bank, .tag_we, .tag_wdata,
        .init_busy, .init_index, .miss_data_ok,
        .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data
    );

    cache_store_buffer u_store_buffer (
        .clk, .resetn, .state, .hit, .hit_way,
        .req_op, .req_index, .req_bank, .req_wstrb, .req_wdata, .hit_word,
        .refill_we, .refill_bank, .victim_way, .ret_valid, .ret_data, .miss_data_ok,
        .bank_we, .bank_wdata, .sb_pending, .sb_busy_index, .sb_busy_bank,
        .data_ok, .rdata
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        sync_ram #(.WIDTH(TAG_W + 1), .LANES(1)) u_tagv (
            .clk, .we(tag_we[w]), .addr(ram_index), .din(tag_wdata), .dout(tagv_rdata[w])
        );
        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            // a pending store borrows this bank for its own set
            assign bank_addr[w*BANKS+b] = (sb_pending && (bank_we[w*BANKS+b] != '0)) ?
                                          sb_busy_index : ram_index;
            sync_ram #(.WIDTH(WORD_W), .LANES(WORD_W / 8)) u_bank (
                .clk, .we(bank_we[w*BANKS+b]), .addr(bank_addr[w*BANKS+b]),
                .din(bank_wdata[b]), .dout(bank_rdata[w*BANKS+b])
            );
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

// memory bus responder with a sparse backing store
module tb_mem_model
    import cache_pkg::*;
#(
    parameter int SETTLE = 25,    // ns after the falling edge
    parameter int SEED   = 23
) (
    input  wire          clk,
    input  wire          resetn,
    input  wire          rd_req,
    input  wire  paddr_t rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output word_t        ret_data,
    input  wire          wr_req,
    input  wire  paddr_t wr_addr,
    input  wire  line_t  wr_data,
    output logic         wr_rdy
);

    word_t  store [int unsigned];    // keyed by word address
    integer seed;
    logic   returning;
    paddr_t ret_base;
    int     ret_cnt;
    int     rd_delay;
    int     wr_delay;
    int     gap;

    // untouched words read back a pattern of their full address
    function automatic word_t init_word(paddr_t addr);
        return (addr ^ 32'h5a5a_0000) * 32'h9e37_79b1;
    endfunction

    function automatic word_t load(paddr_t addr);
        if (store.exists(addr >> 2)) begin
            return store[addr >> 2];
        end
        return init_word(addr);
    endfunction

    initial begin
        seed      = SEED;
        returning = 1'b0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        wr_rdy    = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            rd_rdy    = 1'b0;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            wr_rdy    = 1'b0;
            if (!resetn) begin
                returning = 1'b0;
                ret_cnt   = 0;
                rd_delay  = 0;
                wr_delay  = 0;
                gap       = 0;
            end else begin
                if (returning) begin
                    if (gap == 0) begin
                        ret_valid = 1'b1;
                        ret_last  = (ret_cnt == BANKS - 1);
                        ret_data  = load(paddr_t'(ret_base + 4 * ret_cnt));
                    end else begin
                        gap--;
                    end
                end else begin
                    rd_rdy = rd_req && (rd_delay == 0);    // delay counts only while asked
                    if (rd_req && rd_delay > 0) rd_delay--;
                end
                wr_rdy = (wr_delay == 0);
                if (wr_delay > 0) wr_delay--;

                #SETTLE;
                if (rd_req && rd_rdy) begin
                    returning = 1'b1;
                    ret_base  = rd_addr;
                    ret_cnt   = 0;
                    gap       = $random(seed) & 3;
                end
                if (ret_valid) begin
                    ret_cnt++;
                    gap = $random(seed) & 3;
                    if (ret_last) begin
                        returning = 1'b0;
                        rd_delay  = $random(seed) & 3;
                    end
                end
                if (wr_req) begin
                    for (int b = 0; b < BANKS; b++) begin
                        store[(wr_addr >> 2) + b] = wr_data[WORD_W*b +: WORD_W];
                    end
                    wr_delay = $random(seed) & 3;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cache_top
    import cache_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int SETTLE       = CLK_PERIOD / 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_COLD       = 8;     // two tags in each of the four sets
    localparam int N_STORE      = 16;    // store then read pairs
    localparam int N_EVICT      = 6;
    localparam int N_RANDOM     = 2000;
    localparam int TOTAL_REQ    = 2 * N_COLD + 2 * N_STORE + 2 * N_EVICT + N_RANDOM;

    logic    clk;
    logic    resetn;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    paddr_t  rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;
    logic    wr_req;
    paddr_t  wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    tag_t   tag_pool [6] = '{20'h00000, 20'h00001, 20'h12345, 20'h80000, 20'hfffff, 20'h0a5a5};
    index_t idx_pool [4] = '{8'h00, 8'h01, 8'h7f, 8'hff};

    word_t  model [int unsigned];      // word address to current contents
    bit     written [int unsigned];    // lines stored to with a nonzero mask
    logic   exp_op [$];
    word_t  exp_data [$];
    paddr_t exp_addr [$];
    int     exp_cycle [$];
    integer seed = 23;
    logic   took = 1'b0;
    int     cycle = 0;
    int     checks = 0;
    int     errors = 0;
    int     accepted = 0;
    int     responses = 0;
    int     misses = 0;
    int     writebacks = 0;
    int     max_latency = 0;

    cache_top uut (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    tb_mem_model #(.SETTLE(SETTLE), .SEED(23)) u_mem (
        .clk, .resetn, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // same fill pattern as the memory model
    function automatic word_t init_word(paddr_t addr);
        return (addr ^ 32'h5a5a_0000) * 32'h9e37_79b1;
    endfunction

    function automatic word_t model_word(paddr_t addr);
        if (model.exists(addr >> 2)) begin
            return model[addr >> 2];
        end
        return init_word(addr);
    endfunction

    function automatic line_t model_line(paddr_t base);
        line_t l;
        for (int b = 0; b < BANKS; b++) begin
            l[WORD_W*b +: WORD_W] = model_word(paddr_t'(base + 4 * b));
        end
        return l;
    endfunction

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic paddr_t make_addr(int i, int t, int bank);
        return {tag_pool[t], idx_pool[i], 2'(bank), 2'b00};
    endfunction

    task automatic check_value(input string name, input line_t expected, input line_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    // model takes the store when the cache accepts it
    task automatic accept();
        paddr_t addr;
        word_t  w;
        addr = {tag, index, offset};
        w    = model_word(addr);
        accepted++;
        if (op) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (wstrb[b]) w[8*b +: 8] = wdata[8*b +: 8];
            end
            model[addr >> 2] = w;
            if (wstrb != '0) written[addr >> OFFSET_W] = 1'b1;
        end
        exp_op.push_back(op);
        exp_data.push_back(w);
        exp_addr.push_back(addr);
        exp_cycle.push_back(cycle);
    endtask

    task automatic retire();
        logic  was_write;
        word_t expected;
        int    latency;
        responses++;    // every pulse counts
        check_true(exp_op.size() != 0, "data_ok pulsed with no request outstanding");
        if (exp_op.size() != 0) begin
            was_write = exp_op.pop_front();
            expected  = exp_data.pop_front();
            void'(exp_addr.pop_front());
            latency   = cycle - exp_cycle.pop_front();
            if (latency > max_latency) max_latency = latency;
            if (!was_write) check_value("rdata", expected, rdata);
        end
    endtask

    // everything is sampled a quarter period after the falling edge
    initial begin
        forever begin
            @(negedge clk);
            #SETTLE;
            cycle++;
            if (resetn === 1'b1) begin
                if (data_ok) retire();    // older request first
                took = valid && addr_ok;
                if (took) accept();
                if (rd_req && rd_rdy) begin
                    misses++;
                    check_true(exp_addr.size() != 0, "rd_req with no request outstanding");
                    if (exp_addr.size() != 0) begin
                        check_value("rd_addr", {exp_addr[0][31:OFFSET_W], 4'h0}, rd_addr);
                    end
                end
                if (wr_req) begin
                    writebacks++;
                    check_true(written.exists(wr_addr >> OFFSET_W),
                               "write-back of a line that was never stored to");
                    check_value("wr_addr[3:0]", '0, wr_addr[OFFSET_W-1:0]);
                    if (exp_addr.size() != 0) begin
                        check_value("wr_addr index", exp_addr[0][11:4], wr_addr[11:4]);
                    end
                    check_value("wr_data", model_line({wr_addr[31:OFFSET_W], 4'h0}), wr_data);
                end
            end
        end
    end

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic request(input logic wr, input paddr_t addr, input strb_t be, input word_t data);
        valid  = 1'b1;
        op     = wr;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = wr ? be : '0;
        wdata  = data;
        do @(posedge clk); while (!took);
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_op.size() != 0) @(negedge clk);
    endtask

    initial begin
        int     err_mark;
        int     miss_mark;
        int     wb_mark;
        int     sweep;
        paddr_t a;
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        err_mark = errors;
        sweep    = 0;
        while (addr_ok !== 1'b1) begin
            check_true(rd_req === 1'b0 && wr_req === 1'b0, "memory request during the tag sweep");
            sweep++;
            @(negedge clk);
        end
        check_true(sweep >= SETS, "addr_ok rose before the tag sweep ended");
        miss_mark = misses;
        for (int i = 0; i < N_COLD; i++) begin
            request(1'b0, make_addr(i % 4, i / 4, rand_below(4)), '0, '0);
        end
        drain();
        check_true(misses - miss_mark == N_COLD, "a first read did not miss");
        report("1 reset and cold misses", err_mark);

        err_mark    = errors;
        miss_mark   = misses;
        max_latency = 0;
        for (int i = 0; i < N_COLD; i++) begin
            request(1'b0, make_addr(i % 4, i / 4, rand_below(4)), '0, '0);
        end
        drain();
        check_true(misses == miss_mark, "a read of a resident line missed");
        check_true(max_latency == 1, "a read hit did not answer in the next cycle");
        report("2 read hits", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_STORE; i++) begin
            a = make_addr(rand_below(4), rand_below(6), rand_below(4));
            request(1'b1, a, strb_t'($random(seed)), $random(seed));
            request(1'b0, a, '0, '0);    // right behind the store
        end
        drain();
        report("3 byte-masked stores", err_mark);

        err_mark = errors;
        wb_mark  = writebacks;
        for (int t = 0; t < N_EVICT; t++) begin
            request(1'b1, make_addr(2, t, t % 4), 4'hf, $random(seed));
        end
        for (int t = 0; t < N_EVICT; t++) begin
            request(1'b0, make_addr(2, t, t % 4), '0, '0);
        end
        drain();
        check_true(writebacks > wb_mark, "no dirty line was written back");
        report("4 dirty write-back", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            a = make_addr(rand_below(4), rand_below(6), rand_below(4));
            if (rand_below(8) == 0) @(negedge clk);    // occasional idle cycle
            if ($random(seed) & 1) begin
                request(1'b1, a, strb_t'($random(seed)), $random(seed));
            end else begin
                request(1'b0, a, '0, '0);
            end
        end
        drain();
        check_true(responses == accepted, "data_ok count differs from accepted requests");
        report("5 random mix", err_mark);

        $display("checks %0d, errors %0d, requests %0d, responses %0d, misses %0d, write-backs %0d",
                 checks, errors, accepted, responses, misses, writebacks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // worst case allowance per request plus the tag sweep
    initial begin
        repeat (RESET_CYCLES + SETS + 400 * TOTAL_REQ) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 RESET_CYCLES + SETS + 400 * TOTAL_REQ);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/cache_pkg.sv
rtl/sync_ram.sv
cache/cache_lookup.sv
cache/cache_miss_ctrl.sv
cache/cache_store_buffer.sv
rtl/cache_top.sv
testbench/tb_mem_model.sv
testbench/tb_cache_top.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_cache_top
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
